// ==== vlog.f ====
hdl/hdc_pkg.sv
hdl/class_fsm.sv
hdl/class_bundler.sv
hdl/class_thresholder.sv
hdl/nonbinary_class_reg.sv
hdl/binary_class_reg.sv
hdl/class_hv_gen_top.sv
verification/class_hv_gen_tb.sv

// ==== Makefile ====
# Verilator build and run of the class vector generator testbench

TOP = class_hv_gen_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vlog.f -o sim_bin

run: compile
	./obj_dir/sim_bin | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
		echo "simulation reported failures"; \
		exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== verification/class_hv_gen_tb.sv ====
`timescale 1ns/10ps

module class_hv_gen_tb;
    import hdc_pkg::*;

    // class_gen_done trails the finished pulse by the whole binarize sweep
    localparam int done_latency = 262;
    localparam int cycle_limit = 20000;

    logic clk = 1'b0;
    logic reset;
    logic en;
    logic start_class_gen;
    logic training_hdc_model;
    logic training_dataset_finished;
    logic [hv_dim-1:0] encoded_hv;
    logic [class_idx_w-1:0] class_select_bits;
    logic busy;
    logic sample_taken;
    logic class_gen_done;
    logic [seq_cycle_count-1:0][dims_per_cc-1:0] bin_class_hvs [num_classes];

    // reference model state
    int model_count [num_classes][hv_dim];
    int model_samples [num_classes];

    int errors = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int latency;
    logic finish_seen;
    logic done_q;

    class_hv_gen_top i_dut (
        .clk                       (clk),
        .reset                     (reset),
        .en                        (en),
        .start_class_gen           (start_class_gen),
        .training_hdc_model        (training_hdc_model),
        .training_dataset_finished (training_dataset_finished),
        .encoded_hv                (encoded_hv),
        .class_select_bits         (class_select_bits),
        .busy                      (busy),
        .sample_taken              (sample_taken),
        .class_gen_done            (class_gen_done),
        .bin_class_hvs             (bin_class_hvs)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [hv_dim-1:0] random_hv();
        logic [hv_dim-1:0] v;
        logic [31:0] r;
        v = '0;
        for (int w = 0; w < hv_dim; w += 16) begin
            r = $urandom();
            v[w +: 16] = r[15:0];
        end
        return v;
    endfunction

    // strict majority over the model counts, tie gives 0
    function automatic logic [hv_dim-1:0] expected_class(input int c);
        logic [hv_dim-1:0] v;
        for (int d = 0; d < hv_dim; d++) begin
            v[d] = (2 * model_count[c][d] > model_samples[c]);
        end
        return v;
    endfunction

    task automatic clear_model();
        for (int c = 0; c < num_classes; c++) begin
            for (int d = 0; d < hv_dim; d++) begin
                model_count[c][d] = 0;
            end
            model_samples[c] = 0;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got == exp) else begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_all_zero();
        for (int c = 0; c < num_classes; c++) begin
            assert (bin_class_hvs[c] == '0) else begin
                $display("MISMATCH bin_class_hvs[%0d]: got %h expected %h",
                         c, bin_class_hvs[c], {hv_dim{1'b0}});
                errors++;
            end
        end
    endtask

    task automatic start_run();
        start_class_gen = 1'b1;
        @(posedge clk);
        #1;
        start_class_gen = 1'b0;
        clear_model();
    endtask

    // offer one sample until the handshake, en optionally dropped for 4 cycles
    task automatic send_sample(input logic [hv_dim-1:0] hv, input int cls, input int stall_at);
        int n;
        logic taken;
        encoded_hv = hv;
        class_select_bits = class_idx_w'(cls);
        training_hdc_model = 1'b1;
        n = 0;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = sample_taken;
            @(posedge clk);
            #1;
            n++;
            if (n == stall_at) en = 1'b0;
            if (n == stall_at + 4) en = 1'b1;
        end
        training_hdc_model = 1'b0;
        for (int d = 0; d < hv_dim; d++) begin
            if (hv[d] && model_count[cls][d] < 255) model_count[cls][d]++;
        end
        if (model_samples[cls] < 255) model_samples[cls]++;
    endtask

    task automatic finish_and_wait(input int stall_at, output int cycles);
        logic done;
        training_dataset_finished = 1'b1;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            training_dataset_finished = 1'b0;
            cycles++;
            if (cycles == stall_at) en = 1'b0;
            if (cycles == stall_at + 6) en = 1'b1;
            @(negedge clk);
            done = class_gen_done;
        end
        // let the done-edge comparison run
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", num, name, errors - errors_before);
            tests_failed++;
        end
    endtask

    always @(posedge clk) begin
        if (reset || start_class_gen) begin
            finish_seen <= 1'b0;
        end else if (training_dataset_finished) begin
            finish_seen <= 1'b1;
        end
    end

    a_done_after_finish: assert property (@(posedge clk) disable iff (reset)
        $rose(class_gen_done) |-> finish_seen)
    else begin
        $display("class_gen_done rose without a preceding dataset finished pulse");
        errors++;
    end

    a_taken_while_offered: assert property (@(posedge clk) disable iff (reset)
        sample_taken |-> training_hdc_model)
    else begin
        $display("sample_taken pulsed while no sample was offered");
        errors++;
    end

    // every class against the model once done rises
    always @(posedge clk) begin
        logic [hv_dim-1:0] exp;
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= class_gen_done;
            if (class_gen_done && !done_q) begin
                for (int c = 0; c < num_classes; c++) begin
                    exp = expected_class(c);
                    assert (bin_class_hvs[c] == exp) else begin
                        $display("MISMATCH bin_class_hvs[%0d]: got %h expected %h",
                                 c, bin_class_hvs[c], exp);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        int e0;
        reset = 1'b1;
        en = 1'b1;
        start_class_gen = 1'b0;
        training_hdc_model = 1'b0;
        training_dataset_finished = 1'b0;
        encoded_hv = '0;
        class_select_bits = '0;
        void'($urandom(32'h244d_882b));
        clear_model();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        e0 = errors;
        check_bit("class_gen_done", class_gen_done, 1'b0);
        check_bit("sample_taken", sample_taken, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_all_zero();
        report_test(1, "reset state", e0);

        e0 = errors;
        start_run();
        send_sample(random_hv(), 0, 0);
        send_sample(random_hv(), 3, 0);
        send_sample(random_hv(), 7, 0);
        send_sample(random_hv(), 12, 0);
        send_sample(random_hv(), 25, 0);
        finish_and_wait(0, latency);
        assert (latency == done_latency) else begin
            $display("class_gen_done came %0d cycles after the finished pulse, not %0d",
                     latency, done_latency);
            errors++;
        end
        report_test(2, "one sample per class", e0);

        e0 = errors;
        start_run();
        repeat (3) send_sample(random_hv(), 5, 0);
        repeat (2) send_sample(random_hv(), 9, 0);
        finish_and_wait(0, latency);
        report_test(3, "majority and tie", e0);

        e0 = errors;
        start_run();
        repeat (300) send_sample({hv_dim{1'b1}}, 2, 0);
        // upper half seen 100 times, a majority only if the sample count wrapped
        repeat (100) send_sample({{(hv_dim/2){1'b1}}, {(hv_dim/2){1'b0}}}, 8, 0);
        repeat (160) send_sample({hv_dim{1'b0}}, 8, 0);
        repeat (40) send_sample(random_hv(), int'($urandom() % num_classes), 0);
        finish_and_wait(0, latency);
        report_test(4, "saturation and mixed stream", e0);

        e0 = errors;
        start_run();
        send_sample(random_hv(), 4, 0);
        send_sample(random_hv(), 4, 4);
        send_sample(random_hv(), 11, 6);
        send_sample(random_hv(), 4, 0);
        finish_and_wait(100, latency);
        report_test(5, "enable stalls", e0);

        e0 = errors;
        start_run();
        // clear sweep is 26 cycles
        repeat (28) @(posedge clk);
        #1;
        check_bit("class_gen_done", class_gen_done, 1'b0);
        check_bit("busy", busy, 1'b1);
        check_all_zero();
        send_sample(random_hv(), 1, 0);
        send_sample(random_hv(), 1, 0);
        send_sample(random_hv(), 1, 0);
        send_sample(random_hv(), 20, 0);
        finish_and_wait(0, latency);
        report_test(6, "restart clears results", e0);

        $display("tests: 6 run, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/class_hv_gen_top.sv ====
`timescale 1ns/10ps

module class_hv_gen_top (
    input  logic                                                          clk,
    input  logic                                                          reset,
    input  logic                                                          en,
    input  logic                                                          start_class_gen,
    input  logic                                                          training_hdc_model,
    input  logic                                                          training_dataset_finished,
    input  logic [hdc_pkg::hv_dim-1:0]                                    encoded_hv,
    input  logic [hdc_pkg::class_idx_w-1:0]                               class_select_bits,
    output logic                                                          busy,
    output logic                                                          sample_taken,
    output logic                                                          class_gen_done,
    output logic [hdc_pkg::seq_cycle_count-1:0][hdc_pkg::dims_per_cc-1:0] bin_class_hvs
                                                                          [hdc_pkg::num_classes]
);
    import hdc_pkg::*;

    // controller outputs
    logic [chunk_idx_w-1:0] nonbin_ctr;
    logic [chunk_idx_w-1:0] bin_ctr;
    logic [class_idx_w-1:0] binarized_class_counter;
    logic                   clearing;
    logic                   adjusting_nonbin_class_hvs;
    logic                   binarizing_class_hvs;
    logic                   bin_write;

    // datapath
    logic [dims_per_cc-1:0]                       input_hv_chunk;
    logic [dims_per_cc-1:0][bitwidth_per_dim-1:0] nonbin_class_reg_out;
    logic [dims_per_cc-1:0][bitwidth_per_dim-1:0] nonbin_class_reg_in;
    logic [bitwidth_per_dim-1:0]                  class_sample_count;
    logic [dims_per_cc-1:0]                       bin_class_reg_in;

    class_fsm i_fsm (
        .clk                        (clk),
        .reset                      (reset),
        .en                         (en),
        .start_class_gen            (start_class_gen),
        .training_hdc_model         (training_hdc_model),
        .training_dataset_finished  (training_dataset_finished),
        .nonbin_ctr                 (nonbin_ctr),
        .bin_ctr                    (bin_ctr),
        .binarized_class_counter    (binarized_class_counter),
        .clearing                   (clearing),
        .adjusting_nonbin_class_hvs (adjusting_nonbin_class_hvs),
        .binarizing_class_hvs       (binarizing_class_hvs),
        .bin_write                  (bin_write),
        .sample_taken               (sample_taken),
        .busy                       (busy),
        .class_gen_done             (class_gen_done)
    );

    class_bundler i_bundler (
        .input_hv_chunk  (input_hv_chunk),
        .stored_hv_chunk (nonbin_class_reg_out),
        .sum             (nonbin_class_reg_in)
    );

    class_thresholder i_thresholder (
        .clk                  (clk),
        .reset                (reset),
        .en                   (en),
        .binarizing_class_hvs (binarizing_class_hvs),
        .nonbin_class_reg_out (nonbin_class_reg_out),
        .class_sample_count   (class_sample_count),
        .thresholded_hv       (bin_class_reg_in)
    );

    nonbinary_class_reg i_nonbin_reg (
        .clk                        (clk),
        .reset                      (reset),
        .en                         (en),
        .clearing                   (clearing),
        .adjusting_nonbin_class_hvs (adjusting_nonbin_class_hvs),
        .binarizing_class_hvs       (binarizing_class_hvs),
        .class_select_bits          (class_select_bits),
        .binarized_class_counter    (binarized_class_counter),
        .nonbin_ctr                 (nonbin_ctr),
        .bin_ctr                    (bin_ctr),
        .nonbin_class_reg_in        (nonbin_class_reg_in),
        .nonbin_class_reg_out       (nonbin_class_reg_out),
        .class_sample_count         (class_sample_count)
    );

    binary_class_reg i_bin_reg (
        .clk               (clk),
        .reset             (reset),
        .en                (en),
        .clearing          (clearing),
        .bin_write         (bin_write),
        .class_select_bits (binarized_class_counter),
        .bin_ctr           (bin_ctr),
        .bin_class_reg_in  (bin_class_reg_in),
        .bin_class_hvs     (bin_class_hvs)
    );

    // chunk k is encoded_hv[8k+7:8k]
    always_comb begin
        input_hv_chunk = encoded_hv[dims_per_cc-1:0];
        for (int k = 1; k < seq_cycle_count; k++) begin
            if (nonbin_ctr == chunk_idx_w'(k)) begin
                input_hv_chunk = encoded_hv[k*dims_per_cc +: dims_per_cc];
            end
        end
    end

endmodule

// ==== hdl/binary_class_reg.sv ====
`timescale 1ns/10ps

module binary_class_reg (
    input  logic                                                          clk,
    input  logic                                                          reset,
    input  logic                                                          en,
    input  logic                                                          clearing,
    input  logic                                                          bin_write,
    input  logic [hdc_pkg::class_idx_w-1:0]                               class_select_bits,
    input  logic [hdc_pkg::chunk_idx_w-1:0]                               bin_ctr,
    input  logic [hdc_pkg::dims_per_cc-1:0]                               bin_class_reg_in,
    output logic [hdc_pkg::seq_cycle_count-1:0][hdc_pkg::dims_per_cc-1:0] bin_class_hvs
                                                                          [hdc_pkg::num_classes]
);
    import hdc_pkg::*;

    logic [seq_cycle_count-1:0][dims_per_cc-1:0] class_mem [num_classes];

    // write address trails the read by the thresholder stage
    logic [class_idx_w-1:0] wr_class;
    logic [chunk_idx_w-1:0] wr_chunk;

    assign bin_class_hvs = class_mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_class <= '0;
            wr_chunk <= '0;
        end else if (en) begin
            wr_class <= class_select_bits;
            wr_chunk <= bin_ctr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < num_classes; c++) begin
                class_mem[c] <= '0;
            end
        end else if (en) begin
            if (clearing) begin
                // undelayed index during the clear sweep
                class_mem[class_select_bits] <= '0;
            end else if (bin_write) begin
                class_mem[wr_class][wr_chunk] <= bin_class_reg_in;
            end
        end
    end

endmodule

// ==== hdl/nonbinary_class_reg.sv ====
`timescale 1ns/10ps

module nonbinary_class_reg (
    input  logic                                                           clk,
    input  logic                                                           reset,
    input  logic                                                           en,
    input  logic                                                           clearing,
    input  logic                                                           adjusting_nonbin_class_hvs,
    input  logic                                                           binarizing_class_hvs,
    input  logic [hdc_pkg::class_idx_w-1:0]                                class_select_bits,
    input  logic [hdc_pkg::class_idx_w-1:0]                                binarized_class_counter,
    input  logic [hdc_pkg::chunk_idx_w-1:0]                                nonbin_ctr,
    input  logic [hdc_pkg::chunk_idx_w-1:0]                                bin_ctr,
    input  logic [hdc_pkg::dims_per_cc-1:0][hdc_pkg::bitwidth_per_dim-1:0] nonbin_class_reg_in,
    output logic [hdc_pkg::dims_per_cc-1:0][hdc_pkg::bitwidth_per_dim-1:0] nonbin_class_reg_out,
    output logic [hdc_pkg::bitwidth_per_dim-1:0]                           class_sample_count
);
    import hdc_pkg::*;

    // count vectors, one entry per class and chunk
    logic [dims_per_cc-1:0][bitwidth_per_dim-1:0] count_mem [num_classes][seq_cycle_count];
    logic [bitwidth_per_dim-1:0]                  sample_mem [num_classes];

    logic [class_idx_w-1:0] rd_class;
    logic [chunk_idx_w-1:0] rd_chunk;
    logic                   last_chunk;

    // training class normally, sweep class while binarizing
    assign rd_class = binarizing_class_hvs ? binarized_class_counter : class_select_bits;
    assign rd_chunk = binarizing_class_hvs ? bin_ctr : nonbin_ctr;

    assign nonbin_class_reg_out = count_mem[rd_class][rd_chunk];
    assign class_sample_count = sample_mem[rd_class];

    assign last_chunk = (nonbin_ctr == chunk_idx_w'(seq_cycle_count - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < num_classes; c++) begin
                for (int k = 0; k < seq_cycle_count; k++) begin
                    count_mem[c][k] <= '0;
                end
                sample_mem[c] <= '0;
            end
        end else if (en) begin
            if (clearing) begin
                // clear sweep, one whole class per cycle
                for (int k = 0; k < seq_cycle_count; k++) begin
                    count_mem[binarized_class_counter][k] <= '0;
                end
                sample_mem[binarized_class_counter] <= '0;
            end else if (adjusting_nonbin_class_hvs) begin
                count_mem[class_select_bits][nonbin_ctr] <= nonbin_class_reg_in;

                // sample counted once, on the final chunk
                if (last_chunk && (sample_mem[class_select_bits] != count_max)) begin
                    sample_mem[class_select_bits] <= sample_mem[class_select_bits] + 1'b1;
                end
            end
        end
    end

    a_class_in_range: assert property (@(posedge clk) disable iff (reset)
        adjusting_nonbin_class_hvs |-> (class_select_bits < num_classes));

endmodule

// ==== hdl/class_thresholder.sv ====
`timescale 1ns/10ps

module class_thresholder (
    input  logic                                                           clk,
    input  logic                                                           reset,
    input  logic                                                           en,
    input  logic                                                           binarizing_class_hvs,
    input  logic [hdc_pkg::dims_per_cc-1:0][hdc_pkg::bitwidth_per_dim-1:0] nonbin_class_reg_out,
    input  logic [hdc_pkg::bitwidth_per_dim-1:0]                           class_sample_count,
    output logic [hdc_pkg::dims_per_cc-1:0]                                thresholded_hv
);
    import hdc_pkg::*;

    logic [dims_per_cc-1:0]    majority;
    logic [bitwidth_per_dim:0] sample_ext;

    assign sample_ext = {1'b0, class_sample_count};

    // strict majority, a tie gives 0
    always_comb begin
        for (int d = 0; d < dims_per_cc; d++) begin
            majority[d] = ({nonbin_class_reg_out[d], 1'b0} > sample_ext);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            thresholded_hv <= '0;
        end else if (en && binarizing_class_hvs) begin
            thresholded_hv <= majority;
        end
    end

endmodule

// ==== hdl/class_bundler.sv ====
`timescale 1ns/10ps

module class_bundler (
    input  logic [hdc_pkg::dims_per_cc-1:0]                                input_hv_chunk,
    input  logic [hdc_pkg::dims_per_cc-1:0][hdc_pkg::bitwidth_per_dim-1:0] stored_hv_chunk,
    output logic [hdc_pkg::dims_per_cc-1:0][hdc_pkg::bitwidth_per_dim-1:0] sum
);
    import hdc_pkg::*;

    // each input bit adds one to its dimension count
    always_comb begin
        for (int d = 0; d < dims_per_cc; d++) begin
            if (stored_hv_chunk[d] == count_max) begin
                // saturated, hold at max
                sum[d] = count_max;
            end else begin
                sum[d] = stored_hv_chunk[d] + bitwidth_per_dim'(input_hv_chunk[d]);
            end
        end
    end

endmodule

// ==== hdl/class_fsm.sv ====
`timescale 1ns/10ps

module class_fsm (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            en,
    input  logic                            start_class_gen,
    input  logic                            training_hdc_model,
    input  logic                            training_dataset_finished,
    output logic [hdc_pkg::chunk_idx_w-1:0] nonbin_ctr,
    output logic [hdc_pkg::chunk_idx_w-1:0] bin_ctr,
    output logic [hdc_pkg::class_idx_w-1:0] binarized_class_counter,
    output logic                            clearing,
    output logic                            adjusting_nonbin_class_hvs,
    output logic                            binarizing_class_hvs,
    output logic                            bin_write,
    output logic                            sample_taken,
    output logic                            busy,
    output logic                            class_gen_done
);
    import hdc_pkg::*;

    logic [fsm_state_w-1:0] state;
    logic                   nonbin_last;
    logic                   bin_last;
    logic                   class_last;
    logic                   finish_take;

    assign nonbin_last = (nonbin_ctr == chunk_idx_w'(seq_cycle_count - 1));
    assign bin_last = (bin_ctr == chunk_idx_w'(seq_cycle_count - 1));
    assign class_last = (binarized_class_counter == class_idx_w'(num_classes - 1));

    // end of dataset only counts between sample sweeps
    assign finish_take = (state == fsm_train) && training_dataset_finished &&
                         (nonbin_ctr == '0);

    assign clearing = (state == fsm_clear);
    assign adjusting_nonbin_class_hvs = (state == fsm_train) && training_hdc_model && !finish_take;
    assign binarizing_class_hvs = (state == fsm_binarize);
    assign busy = (state != fsm_idle);

    // handshake on the tenth chunk, only when the sweep really advances
    assign sample_taken = adjusting_nonbin_class_hvs && nonbin_last && en;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fsm_idle;
            nonbin_ctr <= '0;
            bin_ctr <= '0;
            binarized_class_counter <= '0;
            bin_write <= 1'b0;
            class_gen_done <= 1'b0;
        end else if (en) begin
            // matches the thresholder output register
            bin_write <= binarizing_class_hvs;

            case (state)
                fsm_idle: begin
                    if (start_class_gen) begin
                        state <= fsm_clear;
                        class_gen_done <= 1'b0;
                        binarized_class_counter <= '0;
                    end
                end
                fsm_clear: begin
                    // one class zeroed per cycle
                    if (class_last) begin
                        state <= fsm_train;
                        binarized_class_counter <= '0;
                        nonbin_ctr <= '0;
                    end else begin
                        binarized_class_counter <= binarized_class_counter + 1'b1;
                    end
                end
                fsm_train: begin
                    if (finish_take) begin
                        state <= fsm_binarize;
                        bin_ctr <= '0;
                        binarized_class_counter <= '0;
                    end else if (adjusting_nonbin_class_hvs) begin
                        nonbin_ctr <= nonbin_last ? '0 : nonbin_ctr + 1'b1;
                    end
                end
                fsm_binarize: begin
                    if (bin_last) begin
                        bin_ctr <= '0;
                        if (class_last) begin
                            state <= fsm_done;
                            binarized_class_counter <= '0;
                        end else begin
                            binarized_class_counter <= binarized_class_counter + 1'b1;
                        end
                    end else begin
                        bin_ctr <= bin_ctr + 1'b1;
                    end
                end
                fsm_done: begin
                    // last chunk lands in the binary store this cycle
                    state <= fsm_idle;
                    class_gen_done <= 1'b1;
                end
                default: begin
                    state <= fsm_idle;
                end
            endcase
        end
    end

    // binarize sweep, including its trailing write, never overlaps training
    a_no_adjust_during_bin_write: assert property (@(posedge clk) disable iff (reset)
        !(adjusting_nonbin_class_hvs && bin_write));

    a_chunk_ctrs_in_range: assert property (@(posedge clk) disable iff (reset)
        (nonbin_ctr < seq_cycle_count) && (bin_ctr < seq_cycle_count));

endmodule

// ==== hdl/hdc_pkg.sv ====
package hdc_pkg;

    // hypervector geometry
    localparam int hv_dim = 80;
    localparam int dims_per_cc = 8;

    // chunks per hypervector, one chunk per clock
    localparam int seq_cycle_count = hv_dim / dims_per_cc;

    // per-dimension and per-class counter width
    localparam int bitwidth_per_dim = 8;

    // saturation value shared by the dimension and sample counters
    localparam logic [bitwidth_per_dim-1:0] count_max = '1;

    // class labels 0 to 25
    localparam int num_classes = 26;

    // index widths
    localparam int class_idx_w = 5;
    localparam int chunk_idx_w = 4;

    // controller state codes
    localparam int fsm_state_w = 3;

    localparam logic [fsm_state_w-1:0] fsm_idle = 3'd0;
    localparam logic [fsm_state_w-1:0] fsm_clear = 3'd1;
    localparam logic [fsm_state_w-1:0] fsm_train = 3'd2;
    localparam logic [fsm_state_w-1:0] fsm_binarize = 3'd3;

    // one drain cycle for the last thresholded chunk
    localparam logic [fsm_state_w-1:0] fsm_done = 3'd4;

endpackage
